/* csr_pkg.sv */
// Shared widths, slot indices, addresses and reset values of the machine-mode CSR unit.

package csr_pkg;

  // ********************
  // Widths and counts
  // ********************

  localparam int XLEN   = 64;  // CSR and pc width.
  localparam int CSR_AW = 12;  // CSR address width.
  localparam int NR_CSR = 4;   // Implemented CSRs.

  // ********************
  // Slot indices
  // ********************

  // Position of each CSR in the slot array and on the flattened buses.
  localparam int SLOT_MSTATUS = 0;
  localparam int SLOT_MTVEC   = 1;
  localparam int SLOT_MEPC    = 2;
  localparam int SLOT_MCAUSE  = 3;

  // ********************
  // CSR addresses
  // ********************

  localparam logic [CSR_AW-1:0] ADDR_MSTATUS = 12'h300;
  localparam logic [CSR_AW-1:0] ADDR_MTVEC   = 12'h305;
  localparam logic [CSR_AW-1:0] ADDR_MEPC    = 12'h341;
  localparam logic [CSR_AW-1:0] ADDR_MCAUSE  = 12'h342;

  // ********************
  // Fixed values
  // ********************

  // MPP = machine, SXL/UXL = 64 bit.
  // Loaded at reset and again by mret.
  localparam logic [XLEN-1:0] MSTATUS_INIT = 64'ha00001800;

  // Environment call from M-mode.
  localparam logic [XLEN-1:0] CAUSE_ECALL_M = 64'd11;

endpackage

/* csr_decode.sv */
// Address decoder of the CSR unit, instantiated once by the top level.

`timescale 1ns/1ps

module csr_decode #(
  parameter int NR_P = csr_pkg::NR_CSR
) (
  input  logic [csr_pkg::CSR_AW-1:0] i_waddr,
  input  logic                       i_wen,
  input  logic [csr_pkg::CSR_AW-1:0] i_raddr,
  output logic [NR_P-1:0]            o_sw_we,
  output logic [NR_P-1:0]            o_rd_sel
);

  import csr_pkg::*;

  // Address held by a slot index.
  function automatic logic [CSR_AW-1:0] slot_addr(input int idx);
    logic [CSR_AW-1:0] addr;
    case (idx)
      SLOT_MSTATUS: addr = ADDR_MSTATUS;
      SLOT_MTVEC:   addr = ADDR_MTVEC;
      SLOT_MEPC:    addr = ADDR_MEPC;
      SLOT_MCAUSE:  addr = ADDR_MCAUSE;
      default:      addr = '0;
    endcase
    return addr;
  endfunction

  // ********************
  // Per-slot compare
  // ********************

  for (genvar i = 0; i < NR_P; i++) begin : g_dec
    logic w_hit;
    logic r_hit;

    if (i < NR_CSR) begin : g_known
      assign w_hit = (i_waddr == slot_addr(i));
      assign r_hit = (i_raddr == slot_addr(i));
    end else begin : g_spare
      // Slot without an address. Never selected.
      assign w_hit = 1'b0;
      assign r_hit = 1'b0;
    end

    assign o_sw_we[i]  = i_wen & w_hit;  // Qualified by the strobe.
    assign o_rd_sel[i] = r_hit;           // Strobe applied in the read mux.
  end

endmodule

/* csr_slot.sv */
// One CSR register with a software write port and a priority trap write port.

`timescale 1ns/1ps

module csr_slot #(
  parameter int                     XLEN_P    = csr_pkg::XLEN,
  parameter logic [XLEN_P-1:0]      RESET_VAL = '0
) (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_sw_we,
  input  logic [XLEN_P-1:0] i_sw_wdata,
  input  logic              i_hw_we,
  input  logic [XLEN_P-1:0] i_hw_wdata,
  output logic [XLEN_P-1:0] o_q
);

  logic [XLEN_P-1:0] q;

  // ********************
  // Register
  // ********************

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      q <= RESET_VAL;
    end else if (i_hw_we) begin
      // Trap update wins over a software write in the same cycle.
      q <= i_hw_wdata;
    end else if (i_sw_we) begin
      q <= i_sw_wdata;
    end
  end

  assign o_q = q;  // Visible one cycle after the write.

endmodule

/* csr_trap_ctrl.sv */
// Trap-side CSR updates and pc redirect for ecall and mret, used by the CSR unit top.

`timescale 1ns/1ps

module csr_trap_ctrl #(
  parameter int XLEN_P = csr_pkg::XLEN,
  parameter int NR_P   = csr_pkg::NR_CSR
) (
  input  logic                     i_ecall,
  input  logic                     i_mret,
  input  logic [XLEN_P-1:0]        i_epc,
  input  logic [XLEN_P-1:0]        i_mtvec,
  input  logic [XLEN_P-1:0]        i_mepc,
  output logic [NR_P-1:0]          o_hw_we,
  output logic [NR_P*XLEN_P-1:0]   o_hw_wdata,
  output logic [XLEN_P-1:0]        o_nextpc,
  output logic                     o_change_pc
);

  import csr_pkg::*;

  localparam logic [XLEN_P-1:0] STATUS_VAL = XLEN_P'(MSTATUS_INIT);
  localparam logic [XLEN_P-1:0] CAUSE_VAL  = XLEN_P'(CAUSE_ECALL_M);

  // ********************
  // Trap decisions
  // ********************

  always_comb begin
    o_hw_we     = '0;
    o_hw_wdata  = '0;
    o_nextpc    = '0;
    o_change_pc = 1'b0;

    if (i_ecall) begin
      // Save the trapping pc and cause, jump to the handler.
      o_hw_we[SLOT_MEPC]                            = 1'b1;
      o_hw_wdata[SLOT_MEPC*XLEN_P +: XLEN_P]        = i_epc;
      o_hw_we[SLOT_MCAUSE]                          = 1'b1;
      o_hw_wdata[SLOT_MCAUSE*XLEN_P +: XLEN_P]      = CAUSE_VAL;
      o_nextpc    = i_mtvec;  // Value before this edge's update.
      o_change_pc = 1'b1;
    end else if (i_mret) begin
      // Restore status, return to the saved pc.
      o_hw_we[SLOT_MSTATUS]                         = 1'b1;
      o_hw_wdata[SLOT_MSTATUS*XLEN_P +: XLEN_P]     = STATUS_VAL;
      o_nextpc    = i_mepc;
      o_change_pc = 1'b1;
    end
  end

endmodule

/* csr_read_mux.sv */
// Read multiplexer that drives the selected CSR onto the read bus of the CSR unit.

`timescale 1ns/1ps

module csr_read_mux #(
  parameter int XLEN_P = csr_pkg::XLEN,
  parameter int NR_P   = csr_pkg::NR_CSR
) (
  input  logic [NR_P*XLEN_P-1:0] i_slot_q,
  input  logic [NR_P-1:0]        i_rd_sel,
  input  logic                   i_ren,
  output logic [XLEN_P-1:0]      o_rdata
);

  logic [XLEN_P-1:0] sel_data;

  // ********************
  // AND-OR select
  // ********************

  // Select is one-hot or empty, so OR of masked slots is the value.
  always_comb begin
    sel_data = '0;
    for (int i = 0; i < NR_P; i++) begin
      sel_data = sel_data | (i_slot_q[i*XLEN_P +: XLEN_P] & {XLEN_P{i_rd_sel[i]}});
    end
  end

  // Zero when no read is requested.
  assign o_rdata = i_ren ? sel_data : '0;

endmodule

/* csr_unit.sv */
// Top level of the machine-mode CSR unit, instantiated by the core or the testbench.

`timescale 1ns/1ps

module csr_unit (
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  logic [csr_pkg::CSR_AW-1:0] i_raddr,
  input  logic                       i_ren,
  input  logic [csr_pkg::CSR_AW-1:0] i_waddr,
  input  logic                       i_wen,
  input  logic [csr_pkg::XLEN-1:0]   i_wdata,
  input  logic [csr_pkg::XLEN-1:0]   i_epc,
  input  logic                       i_ecall,
  input  logic                       i_mret,
  output logic [csr_pkg::XLEN-1:0]   o_rdata,
  output logic [csr_pkg::XLEN-1:0]   o_nextpc,
  output logic                       o_change_pc
);

  import csr_pkg::*;

  localparam int XLEN_P = XLEN;
  localparam int NR_P   = NR_CSR;

  logic [NR_P-1:0]        sw_we;
  logic [NR_P-1:0]        rd_sel;
  logic [NR_P-1:0]        hw_we;
  logic [NR_P*XLEN_P-1:0] hw_wdata;
  logic [NR_P*XLEN_P-1:0] slot_q;

  // ********************
  // Address decode
  // ********************

  csr_decode #(
    .NR_P (NR_P)
  ) u_decode (
    .i_waddr  (i_waddr),
    .i_wen    (i_wen),
    .i_raddr  (i_raddr),
    .o_sw_we  (sw_we),
    .o_rd_sel (rd_sel)
  );

  // ********************
  // CSR slots
  // ********************

  for (genvar i = 0; i < NR_P; i++) begin : g_slot
    // Only mstatus comes out of reset nonzero.
    localparam logic [XLEN_P-1:0] RST_VAL =
      (i == SLOT_MSTATUS) ? XLEN_P'(MSTATUS_INIT) : '0;

    csr_slot #(
      .XLEN_P    (XLEN_P),
      .RESET_VAL (RST_VAL)
    ) u_slot (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_sw_we    (sw_we[i]),
      .i_sw_wdata (i_wdata),
      .i_hw_we    (hw_we[i]),
      .i_hw_wdata (hw_wdata[i*XLEN_P +: XLEN_P]),
      .o_q        (slot_q[i*XLEN_P +: XLEN_P])
    );
  end

  // ********************
  // Trap control
  // ********************

  csr_trap_ctrl #(
    .XLEN_P (XLEN_P),
    .NR_P   (NR_P)
  ) u_trap_ctrl (
    .i_ecall     (i_ecall),
    .i_mret      (i_mret),
    .i_epc       (i_epc),
    .i_mtvec     (slot_q[SLOT_MTVEC*XLEN_P +: XLEN_P]),
    .i_mepc      (slot_q[SLOT_MEPC*XLEN_P +: XLEN_P]),
    .o_hw_we     (hw_we),
    .o_hw_wdata  (hw_wdata),
    .o_nextpc    (o_nextpc),
    .o_change_pc (o_change_pc)
  );

  // Combinational read path.
  csr_read_mux #(
    .XLEN_P (XLEN_P),
    .NR_P   (NR_P)
  ) u_read_mux (
    .i_slot_q (slot_q),
    .i_rd_sel (rd_sel),
    .i_ren    (i_ren),
    .o_rdata  (o_rdata)
  );

endmodule

/* tb_csr_unit.sv */
// Random-stimulus testbench for the CSR unit, checked against a reference model of the four CSRs.

`timescale 1ns/1ps

module tb_csr_unit;

  // ********************
  // Constants
  // ********************

  localparam logic [11:0] A_MSTATUS = 12'h300;
  localparam logic [11:0] A_MTVEC   = 12'h305;
  localparam logic [11:0] A_MEPC    = 12'h341;
  localparam logic [11:0] A_MCAUSE  = 12'h342;

  localparam int S_MSTATUS = 0;
  localparam int S_MTVEC   = 1;
  localparam int S_MEPC    = 2;
  localparam int S_MCAUSE  = 3;

  localparam logic [63:0] STATUS_RST  = 64'ha00001800;  // After reset and after mret.
  localparam logic [63:0] CAUSE_ECALL = 64'd11;

  // Run length in cycles.
  localparam int RST_CYCLES      = 8;
  localparam int MID_RST_CYCLES  = 3;
  localparam int READ_CYCLES     = 4;
  localparam int N_RANDOM        = 500;
  localparam int DIRECTED_CYCLES = 16;
  localparam int TOTAL_CYCLES    = RST_CYCLES + READ_CYCLES + N_RANDOM + MID_RST_CYCLES +
                                   READ_CYCLES + DIRECTED_CYCLES + READ_CYCLES;
  localparam int TIMEOUT_CYCLES  = 2 * TOTAL_CYCLES;

  logic        i_clk;
  logic        i_rst;
  logic [11:0] i_raddr;
  logic        i_ren;
  logic [11:0] i_waddr;
  logic        i_wen;
  logic [63:0] i_wdata;
  logic [63:0] i_epc;
  logic        i_ecall;
  logic        i_mret;
  logic [63:0] o_rdata;
  logic [63:0] o_nextpc;
  logic        o_change_pc;

  integer      seed;
  int          cycle_cnt = 0;
  logic [63:0] model_csr [0:3];  // Reference copy of the CSRs.

  csr_unit dut0 (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_raddr     (i_raddr),
    .i_ren       (i_ren),
    .i_waddr     (i_waddr),
    .i_wen       (i_wen),
    .i_wdata     (i_wdata),
    .i_epc       (i_epc),
    .i_ecall     (i_ecall),
    .i_mret      (i_mret),
    .o_rdata     (o_rdata),
    .o_nextpc    (o_nextpc),
    .o_change_pc (o_change_pc)
  );

  initial i_clk = 1'b0;
  always #4 i_clk = ~i_clk;  // 8 ns period.

  // ********************
  // Failure reporting
  // ********************

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      stop_with_failure($sformatf("MISMATCH %s expected 0x%h actual 0x%h", name, exp, act));
    end
  endtask

  always @(posedge i_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      stop_with_failure($sformatf("Timeout, the run did not end within %0d cycles.",
                                  TIMEOUT_CYCLES));
    end
  end

  // ********************
  // Reference model
  // ********************

  // Slot of an address, or -1 when no CSR lives there.
  function automatic int slot_of(input logic [11:0] addr);
    int slot;
    case (addr)
      A_MSTATUS: slot = S_MSTATUS;
      A_MTVEC:   slot = S_MTVEC;
      A_MEPC:    slot = S_MEPC;
      A_MCAUSE:  slot = S_MCAUSE;
      default:   slot = -1;
    endcase
    return slot;
  endfunction

  task automatic reset_model();
    model_csr[S_MSTATUS] = STATUS_RST;
    model_csr[S_MTVEC]   = '0;
    model_csr[S_MEPC]    = '0;
    model_csr[S_MCAUSE]  = '0;
  endtask

  // Checks the outputs just before the edge, then follows the edge in the model.
  task automatic run_cycle();
    int          rslot;
    int          wslot;
    logic [63:0] exp_rdata;
    logic [63:0] exp_nextpc;
    logic        exp_change;
    #6;
    rslot      = slot_of(i_raddr);
    wslot      = slot_of(i_waddr);
    exp_rdata  = '0;
    exp_nextpc = '0;
    exp_change = i_ecall | i_mret;
    if (i_ren && rslot >= 0) begin
      exp_rdata = model_csr[rslot];
    end
    if (i_ecall) begin
      exp_nextpc = model_csr[S_MTVEC];
    end else if (i_mret) begin
      exp_nextpc = model_csr[S_MEPC];
    end
    check_value("o_rdata", exp_rdata, o_rdata);
    check_value("o_nextpc", exp_nextpc, o_nextpc);
    check_value("o_change_pc", {63'd0, exp_change}, {63'd0, o_change_pc});

    if (i_rst) begin
      reset_model();
    end else begin
      if (i_wen && wslot >= 0) begin
        model_csr[wslot] = i_wdata;
      end
      // Trap updates last, so they win.
      if (i_ecall) begin
        model_csr[S_MEPC]   = i_epc;
        model_csr[S_MCAUSE] = CAUSE_ECALL;
      end else if (i_mret) begin
        model_csr[S_MSTATUS] = STATUS_RST;
      end
    end
    @(posedge i_clk);
    #1;  // Next inputs go in just after the edge.
  endtask

  // ********************
  // Stimulus
  // ********************

  task automatic set_idle();
    i_raddr = '0;
    i_ren   = 1'b0;
    i_waddr = '0;
    i_wen   = 1'b0;
    i_wdata = '0;
    i_epc   = '0;
    i_ecall = 1'b0;
    i_mret  = 1'b0;
  endtask

  task automatic apply_reset(input int cycles);
    set_idle();
    i_rst = 1'b1;
    repeat (cycles) run_cycle();
    i_rst = 1'b0;
  endtask

  task automatic read_csr(input logic [11:0] addr);
    set_idle();
    i_raddr = addr;
    i_ren   = 1'b1;
    run_cycle();
  endtask

  task automatic write_csr(input logic [11:0] addr, input logic [63:0] data);
    set_idle();
    i_waddr = addr;
    i_wen   = 1'b1;
    i_wdata = data;
    run_cycle();
  endtask

  task automatic read_all();
    read_csr(A_MSTATUS);
    read_csr(A_MTVEC);
    read_csr(A_MEPC);
    read_csr(A_MCAUSE);
  endtask

  // Known addresses, a random one and a near miss.
  function automatic logic [11:0] addr_for_pick(input int pick, input logic [31:0] raw);
    logic [11:0] addr;
    case (pick)
      0:       addr = A_MSTATUS;
      1:       addr = A_MTVEC;
      2:       addr = A_MEPC;
      3:       addr = A_MCAUSE;
      4:       addr = raw[11:0];
      default: addr = 12'h301;
    endcase
    return addr;
  endfunction

  task automatic random_cycle();
    int pick;
    pick           = $unsigned($random(seed)) % 6;
    i_raddr        = addr_for_pick(pick, $random(seed));
    i_ren          = (($random(seed) & 3) != 0);
    pick           = $unsigned($random(seed)) % 6;
    i_waddr        = addr_for_pick(pick, $random(seed));
    i_wen          = (($random(seed) & 1) != 0);
    i_wdata[63:32] = $random(seed);
    i_wdata[31:0]  = $random(seed);
    i_epc[63:32]   = $random(seed);
    i_epc[31:0]    = $random(seed);
    i_ecall        = (($random(seed) & 7) == 0);
    i_mret         = (($random(seed) & 7) == 0);
    run_cycle();
  endtask

  // Trap collisions with software writes and with each other.
  task automatic directed_collisions();
    write_csr(A_MTVEC, 64'h0000_0000_8000_1000);
    write_csr(A_MEPC, 64'h0000_0000_8000_2000);

    // Ecall against a software write to mepc.
    set_idle();
    i_ecall = 1'b1;
    i_epc   = 64'h0000_0000_8000_0444;
    i_waddr = A_MEPC;
    i_wen   = 1'b1;
    i_wdata = 64'hdead_beef_0000_0001;
    run_cycle();
    read_csr(A_MEPC);
    read_csr(A_MCAUSE);

    // Ecall against a software write to mcause.
    set_idle();
    i_ecall = 1'b1;
    i_epc   = 64'h0000_0000_8000_0888;
    i_waddr = A_MCAUSE;
    i_wen   = 1'b1;
    i_wdata = 64'h0000_0000_0000_0055;
    run_cycle();
    read_csr(A_MCAUSE);
    read_csr(A_MEPC);

    // Ecall and mret together act as an ecall only.
    write_csr(A_MSTATUS, 64'h0000_0000_0000_0088);
    set_idle();
    i_ecall = 1'b1;
    i_mret  = 1'b1;
    i_epc   = 64'h0000_0000_8000_0ccc;
    run_cycle();
    read_csr(A_MSTATUS);

    // Plain mret returns to mepc and restores mstatus.
    set_idle();
    i_mret = 1'b1;
    run_cycle();
    read_csr(A_MSTATUS);
  endtask

  // ********************
  // Test sequence
  // ********************

  initial begin
    seed  = 32'hcbb7_c68c;
    i_rst = 1'b1;
    set_idle();
    for (int i = 0; i < 4; i++) begin
      model_csr[i] = '0;
    end
    @(posedge i_clk);
    #1;

    apply_reset(RST_CYCLES);
    read_all();  // Reset values.

    repeat (N_RANDOM / 2) random_cycle();
    apply_reset(MID_RST_CYCLES);
    read_all();
    repeat (N_RANDOM - N_RANDOM / 2) random_cycle();

    directed_collisions();
    read_all();

    $display("Everything OK");
    $finish;
  end

endmodule

/* sim.f */
csr_pkg.sv
csr_decode.sv
csr_slot.sv
csr_trap_ctrl.sv
csr_read_mux.sv
csr_unit.sv
tb_csr_unit.sv
